// ==== acc_isa_pkg.sv ====
package acc_isa_pkg;

	////////////////////////////////////////////////////////////////////
	// Instruction byte layout
	////////////////////////////////////////////////////////////////////

	// Upper five bits of every instruction byte
	typedef enum logic [4:0] {
		NOP  = 5'h00,	// Does nothing
		LDI  = 5'h01,	// acc <= imm, operand byte follows
		LDR  = 5'h02,	// acc <= reg
		STR  = 5'h03,	// reg <= acc
		ADD  = 5'h04,	// acc <= acc + reg
		SUB  = 5'h05,	// acc <= acc - reg
		AND  = 5'h06,
		XOR  = 5'h07,
		OUT  = 5'h08,	// Port <= acc
		BRA  = 5'h09,	// Conditional branch, target byte follows
		JMP  = 5'h0A,	// Target byte follows
		BSR  = 5'h0B,	// Call, target byte follows
		RTS  = 5'h0C,	// Return from call link
		RTI  = 5'h0D,	// Return from interrupt link, mask back on
		LMSK = 5'h0E,	// Mask <= acc bit 0
		HLT  = 5'h0F	// Stop until reset
	} opcode_t;

	// Low three bits of a BRA, anything else never branches
	typedef enum logic [2:0] {
		CC_EQ = 3'b000,	// Zero flag set
		CC_NE = 3'b001,	// Zero flag clear
		CC_AL = 3'b010	// Always
	} cond_t;

	// Same byte, two decodings
	typedef union packed {
		struct packed {
			opcode_t op;
			cond_t   cond;
		} flow;			// Seen by the sequencer
		struct packed {
			opcode_t    op;
			logic [2:0] ridx;
		} alu;			// Seen by execute
	} instr_u;

	// Interrupt entry address
	localparam logic [7:0] IRQ_VECTOR = 8'hF0;

endpackage

// ==== acc_uarch_pkg.sv ====
package acc_uarch_pkg;

	// Sequencer states, one-hot
	typedef enum logic [14:0] {
		S_RESET    = 15'b000000000000001,	// First cycle out of reset
		S_FETCH    = 15'b000000000000010,	// Opcode byte on mem_data
		S_DECODE   = 15'b000000000000100,
		S_OPERAND  = 15'b000000000001000,	// Immediate byte on mem_data
		S_EXEC     = 15'b000000000010000,	// exec_strobe
		S_JUMP     = 15'b000000000100000,	// pc <= target byte
		S_SKIP     = 15'b000000001000000,	// Branch not taken, step over target
		S_CALL     = 15'b000000010000000,
		S_RTS      = 15'b000000100000000,
		S_RTI      = 15'b000001000000000,
		S_LMSK     = 15'b000010000000000,
		S_IRQ_SAVE = 15'b000100000000000,
		S_IRQ_VEC  = 15'b001000000000000,
		S_HALT     = 15'b010000000000000,
		S_NOP      = 15'b100000000000000	// NOP and unknown opcodes
	} seq_state_t;

	typedef enum logic [2:0] {
		ALU_PASS_IMM, ALU_PASS_REG, ALU_ADD, ALU_SUB,
		ALU_AND, ALU_XOR, ALU_STORE, ALU_OUT
	} alu_op_t;

	localparam int NUM_REGS = 8;	// Register file depth

endpackage

// ==== flow_ctrl.sv ====
module flow_ctrl import acc_isa_pkg::*, acc_uarch_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  instr_u     mem_data,	// Opcode or operand byte, same cycle as pc
	input  logic       irq,
	input  logic       zero_flag,
	input  logic       acc_bit0,	// LMSK source
	output logic [7:0] pc,
	output logic       exec_strobe,
	output alu_op_t    alu_op,
	output logic [2:0] reg_idx,
	output logic [7:0] imm,
	output logic       halted
);

	seq_state_t state, next_state;
	instr_u     ir;				// Current instruction
	logic [7:0] opnd;			// Immediate byte
	logic [7:0] call_link;		// Single level only
	logic [7:0] irq_link;
	logic       mask;
	logic       irq_q;			// Edge detect
	logic       irq_pend;
	logic       take_irq;
	logic       br_taken;

	assign take_irq = irq_pend & mask;

	// Branch condition against the flag, flag write already settled
	always_comb begin
		case (ir.flow.cond)
			CC_AL:   br_taken = 1'b1;
			CC_EQ:   br_taken = zero_flag;
			CC_NE:   br_taken = ~zero_flag;
			default: br_taken = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////////////
	always_comb begin
		next_state = S_FETCH;	// Most states return to fetch
		case (state)
			S_RESET:    next_state = S_FETCH;
			S_FETCH:    next_state = take_irq ? S_IRQ_SAVE : S_DECODE;
			S_DECODE: begin
				case (ir.flow.op)
					LDI:                   next_state = S_OPERAND;
					LDR, STR, ADD, SUB,
					AND, XOR, OUT:         next_state = S_EXEC;
					BRA:                   next_state = br_taken ? S_JUMP : S_SKIP;
					JMP:                   next_state = S_JUMP;
					BSR:                   next_state = S_CALL;
					RTS:                   next_state = S_RTS;
					RTI:                   next_state = S_RTI;
					LMSK:                  next_state = S_LMSK;
					HLT:                   next_state = S_HALT;
					default:               next_state = S_NOP;
				endcase
			end
			S_OPERAND:  next_state = S_EXEC;
			S_IRQ_SAVE: next_state = S_IRQ_VEC;
			S_HALT:     next_state = S_HALT;	// Only reset leaves
			default:    next_state = S_FETCH;
		endcase
	end

	////////////////////////////////////////////////////////////////////
	// State, pc, links and mask
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= S_RESET;
			pc        <= 8'h00;
			mask      <= 1'b0;
			irq_q     <= 1'b0;
			irq_pend  <= 1'b0;
			ir        <= '0;
			opnd      <= 8'h00;
			call_link <= 8'h00;
			irq_link  <= 8'h00;
		end else begin
			state <= next_state;
			irq_q <= irq;
			// Rising edge sets pending, entry clears it
			if (irq && !irq_q)
				irq_pend <= 1'b1;
			else if (state == S_IRQ_SAVE)
				irq_pend <= 1'b0;

			case (state)
				S_FETCH: begin
					if (!take_irq) begin
						ir <= mem_data;
						pc <= pc + 8'd1;	// Now points at operand or next opcode
					end
				end
				S_OPERAND: begin
					opnd <= mem_data;
					pc   <= pc + 8'd1;
				end
				S_JUMP:     pc <= mem_data;	// Target byte sits at pc
				S_SKIP:     pc <= pc + 8'd1;
				S_CALL: begin
					call_link <= pc + 8'd1;	// Past the target byte
					pc        <= mem_data;
				end
				S_RTS:      pc <= call_link;
				S_RTI: begin
					pc   <= irq_link;
					mask <= 1'b1;
				end
				S_LMSK:     mask <= acc_bit0;
				S_IRQ_SAVE: begin
					irq_link <= pc;			// Instruction not yet fetched
					mask     <= 1'b0;
				end
				S_IRQ_VEC:  pc <= IRQ_VECTOR;
				default: ;
			endcase
		end
	end

	// Data op mapping from the ALU view
	always_comb begin
		case (ir.alu.op)
			LDI:     alu_op = ALU_PASS_IMM;
			STR:     alu_op = ALU_STORE;
			ADD:     alu_op = ALU_ADD;
			SUB:     alu_op = ALU_SUB;
			AND:     alu_op = ALU_AND;
			XOR:     alu_op = ALU_XOR;
			OUT:     alu_op = ALU_OUT;
			default: alu_op = ALU_PASS_REG;	// LDR
		endcase
	end

	assign reg_idx     = ir.alu.ridx;
	assign imm         = opnd;
	assign exec_strobe = (state == S_EXEC);	// Moore outputs
	assign halted      = (state == S_HALT);

endmodule

// ==== alu_exec.sv ====
module alu_exec import acc_uarch_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       exec_strobe,
	input  alu_op_t    alu_op,
	input  logic [2:0] reg_idx,
	input  logic [7:0] imm,
	input  logic [7:0] acc,
	output logic       wr_strobe,
	output logic       wr_acc,
	output logic       wr_reg,
	output logic       wr_out,
	output logic [2:0] wr_idx,
	output logic [7:0] wr_value
);

	logic [7:0] rf_copy [NUM_REGS];	// Read side of the register file
	logic [7:0] reg_val;
	logic [7:0] result;

	assign reg_val = rf_copy[reg_idx];

	////////////////////////////////////////////////////////////////////
	// Operation
	////////////////////////////////////////////////////////////////////
	always_comb begin
		case (alu_op)
			ALU_PASS_IMM: result = imm;
			ALU_PASS_REG: result = reg_val;
			ALU_ADD:      result = acc + reg_val;	// No carry kept
			ALU_SUB:      result = acc - reg_val;
			ALU_AND:      result = acc & reg_val;
			ALU_XOR:      result = acc ^ reg_val;
			default:      result = acc;			// STORE and OUT move acc
		endcase
	end

	// Result plus targets, one cycle after exec_strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_strobe <= 1'b0;
			wr_acc    <= 1'b0;
			wr_reg    <= 1'b0;
			wr_out    <= 1'b0;
			wr_idx    <= 3'd0;
			wr_value  <= 8'h00;
		end else begin
			wr_strobe <= exec_strobe;
			if (exec_strobe) begin
				wr_acc   <= (alu_op != ALU_STORE) && (alu_op != ALU_OUT);
				wr_reg   <= (alu_op == ALU_STORE);
				wr_out   <= (alu_op == ALU_OUT);
				wr_idx   <= reg_idx;
				wr_value <= result;
			end
		end
	end

	// Follow own store writes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				rf_copy[i] <= 8'h00;
		end else if (wr_strobe && wr_reg) begin
			rf_copy[wr_idx] <= wr_value;
		end
	end

endmodule

// ==== acc_result.sv ====
module acc_result import acc_uarch_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       wr_strobe,
	input  logic       wr_acc,
	input  logic       wr_reg,
	input  logic       wr_out,
	input  logic [2:0] wr_idx,
	input  logic [7:0] wr_value,
	output logic [7:0] acc,
	output logic       zero_flag,
	output logic [7:0] out_data,
	output logic       out_valid
);

	logic [7:0] regs [NUM_REGS];	// Architectural register file
	logic       do_out;

	assign do_out = wr_strobe & wr_out;

	////////////////////////////////////////////////////////////////////
	// Accumulator, flag, registers
	////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc       <= 8'h00;
			zero_flag <= 1'b0;
			out_valid <= 1'b0;
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= 8'h00;
		end else begin
			out_valid <= do_out;	// One cycle per OUT

			// Flag follows accumulator writes only
			if (wr_strobe && wr_acc) begin
				acc       <= wr_value;
				zero_flag <= (wr_value == 8'h00);
			end

			if (wr_strobe && wr_reg)
				regs[wr_idx] <= wr_value;
		end
	end

	// Port data, qualified by out_valid
	always_ff @(posedge clk) begin
		if (do_out)
			out_data <= wr_value;
	end

endmodule

// ==== acc_cpu.sv ====
module acc_cpu import acc_uarch_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	output logic [7:0] pc,
	input  logic [7:0] mem_data,	// Combinational program memory answer
	input  logic       irq,
	output logic [7:0] out_data,
	output logic       out_valid,
	output logic       halted
);

	// Sequencer to execute
	logic       exec_strobe;
	alu_op_t    alu_op;
	logic [2:0] reg_idx;
	logic [7:0] imm;

	// Execute to result
	logic       wr_strobe;
	logic       wr_acc;
	logic       wr_reg;
	logic       wr_out;
	logic [2:0] wr_idx;
	logic [7:0] wr_value;

	// Feedback
	logic [7:0] acc;
	logic       zero_flag;

	////////////////////////////////////////////////////////////////////
	// Stages
	////////////////////////////////////////////////////////////////////
	flow_ctrl i_flow_ctrl (
		.clk, .arst_n, .mem_data, .irq, .zero_flag,
		.acc_bit0 (acc[0]),
		.pc, .exec_strobe, .alu_op, .reg_idx, .imm, .halted
	);

	alu_exec i_alu_exec (
		.clk, .arst_n, .exec_strobe, .alu_op, .reg_idx, .imm, .acc,
		.wr_strobe, .wr_acc, .wr_reg, .wr_out, .wr_idx, .wr_value
	);

	acc_result i_acc_result (
		.clk, .arst_n, .wr_strobe, .wr_acc, .wr_reg, .wr_out, .wr_idx, .wr_value,
		.acc, .zero_flag, .out_data, .out_valid
	);

endmodule

// ==== acc_cpu_asserts.sv ====
module acc_cpu_asserts import acc_uarch_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  seq_state_t state,
	input  logic       exec_strobe,
	input  logic       halted
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;	// Failed assertion count

	////////////////////////////////////////////////////////////////////
	// Sequencer properties
	////////////////////////////////////////////////////////////////////
	state_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot(state))
		else begin
			fail_count++;
			$error("Sequencer state is not one-hot: %b", state);
		end

	// Execute strobe is a single-cycle pulse
	strobe_single: assert property (@(posedge clk) disable iff (!arst_n)
		exec_strobe |=> !exec_strobe)
		else begin
			fail_count++;
			$error("exec_strobe held high for more than one cycle");
		end

	// Only reset leaves HALT
	halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
		else begin
			fail_count++;
			$error("halted fell while reset was released");
		end

endmodule

bind flow_ctrl acc_cpu_asserts i_flow_asserts (
	.clk, .arst_n, .state, .exec_strobe, .halted
);

// ==== acc_cpu_checker.sv ====
module acc_cpu_checker (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            out_valid,
	input  logic [7:0]      out_data,
	input  logic            halted,
	input  logic [8*12-1:0] test_name,
	input  logic [31:0]     exp_list,	// Byte n at bits 8n+7 down to 8n
	input  logic [2:0]      exp_count,
	output int              err_count,
	output int              check_count
);

	timeunit 1ns;
	timeprecision 100ps;

	int         errs   = 0;
	int         checks = 0;
	int         n_seen = 0;		// Outputs seen in this row
	logic       halt_seen = 1'b0;
	logic [7:0] expected;

	assign err_count   = errs;
	assign check_count = checks;

	////////////////////////////////////////////////////////////////////
	// Output port and halt, sampled mid-cycle
	////////////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		if (!arst_n) begin
			n_seen    = 0;		// New row starts under reset
			halt_seen = 1'b0;
		end else begin
			if (out_valid) begin
				checks++;
				if (n_seen >= exp_count) begin
					errs++;
					$display("Error: %0s produced an extra output byte %02h",
						test_name, out_data);
				end else begin
					expected = exp_list[n_seen*8 +: 8];
					if (out_data !== expected) begin
						errs++;
						$display("Error: %0s output %0d expected %02h actual %02h",
							test_name, n_seen, expected, out_data);
					end
				end
				n_seen++;
			end
			// Count check once per halt
			if (halted && !halt_seen) begin
				halt_seen = 1'b1;
				checks++;
				if (n_seen != exp_count) begin
					errs++;
					$display("Error: %0s output count expected %0d actual %0d",
						test_name, exp_count, n_seen);
				end
			end
		end
	end

endmodule

// ==== acc_cpu_tb.sv ====
module acc_cpu_tb import acc_isa_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic       clk;
	logic       arst_n;
	logic [7:0] pc;
	logic [7:0] mem_data;
	logic       irq;
	logic [7:0] out_data;
	logic       out_valid;
	logic       halted;

	logic [7:0] mem [256];		// Program memory

	// Test table of up to 8 rows
	logic [8*12-1:0] row_name [8];
	logic [7:0]      row_prog [8][16];
	int              row_len  [8];
	logic            row_irq  [8];
	logic [7:0]      row_exp  [8][4];
	int              row_nexp [8];
	int              n_rows;

	logic [8*12-1:0] cur_name;
	logic [31:0]     cur_exp;
	logic [2:0]      cur_nexp;
	int              chk_errors;
	int              chk_checks;
	int              cycles = 0;
	int              cycle_limit = 0;	// Zero until the table is built

	initial clk = 1'b0;
	always #20 clk = ~clk;			// 40 ns period

	assign mem_data = mem[pc];		// Same-cycle answer

	acc_cpu i_dut (
		.clk, .arst_n, .pc, .mem_data, .irq, .out_data, .out_valid, .halted
	);

	acc_cpu_checker i_checker (
		.clk, .arst_n, .out_valid, .out_data, .halted,
		.test_name (cur_name), .exp_list (cur_exp), .exp_count (cur_nexp),
		.err_count (chk_errors), .check_count (chk_checks)
	);

	////////////////////////////////////////////////////////////////////
	// Table helpers
	////////////////////////////////////////////////////////////////////
	// Opcode in the top five bits, cond or register below
	function automatic logic [7:0] encode(input opcode_t op, input logic [2:0] low);
		return {op, low};
	endfunction

	// Program and expected bytes listed first byte leftmost
	task automatic add_row(input logic [8*12-1:0] name, input logic irq_level,
			input logic [8*16-1:0] prog, input int len,
			input logic [31:0] exp, input int nexp);
		row_name[n_rows] = name;
		row_irq[n_rows]  = irq_level;
		row_len[n_rows]  = len;
		row_nexp[n_rows] = nexp;
		for (int i = 0; i < len; i++)
			row_prog[n_rows][i] = prog[(len-1-i)*8 +: 8];
		for (int i = 0; i < nexp; i++)
			row_exp[n_rows][i] = exp[(nexp-1-i)*8 +: 8];
		n_rows++;
	endtask

	task automatic build_table();
		add_row("data_path", 1'b0, {encode(LDI, 3'd0), 8'd5, encode(STR, 3'd2),
			encode(LDI, 3'd0), 8'd3, encode(ADD, 3'd2), encode(OUT, 3'd0),
			encode(SUB, 3'd2), encode(OUT, 3'd0), encode(XOR, 3'd2),
			encode(OUT, 3'd0), encode(HLT, 3'd0)}, 12, {8'd8, 8'd3, 8'd6}, 3);
		// Loop at 7, BEQ at 5 not taken, BRA at 11 skips the OUT at 13
		add_row("branches", 1'b0, {encode(LDI, 3'd0), 8'd1, encode(STR, 3'd1),
			encode(LDI, 3'd0), 8'd3, encode(BRA, CC_EQ), 8'd14,
			encode(SUB, 3'd1), encode(OUT, 3'd0), encode(BRA, CC_NE), 8'd7,
			encode(BRA, CC_AL), 8'd14, encode(OUT, 3'd0), encode(OUT, 3'd0),
			encode(HLT, 3'd0)}, 16, {8'd2, 8'd1, 8'd0, 8'd0}, 4);
		// Subroutine at 8
		add_row("call_return", 1'b0, {encode(LDI, 3'd0), 8'h11, encode(BSR, 3'd0),
			8'd8, encode(LDI, 3'd0), 8'h22, encode(OUT, 3'd0), encode(HLT, 3'd0),
			encode(OUT, 3'd0), encode(RTS, 3'd0)}, 10, {8'h11, 8'h22}, 2);
		// Request held high throughout
		// Masked OUT of 55 comes first, handler runs once LMSK sees acc 1
		add_row("interrupt", 1'b1, {encode(LMSK, 3'd0), encode(LDI, 3'd0), 8'h55,
			encode(OUT, 3'd0), encode(LDI, 3'd0), 8'd1, encode(LMSK, 3'd0),
			encode(LDI, 3'd0), 8'h66, encode(OUT, 3'd0), encode(HLT, 3'd0)}, 11,
			{8'h55, 8'hAA, 8'h66}, 3);
		add_row("jump_halt", 1'b0, {encode(LDI, 3'd0), 8'h3C, encode(JMP, 3'd0),
			8'd5, encode(OUT, 3'd0), encode(NOP, 3'd0), encode(OUT, 3'd0),
			encode(HLT, 3'd0)}, 8, {8'h3C}, 1);
	endtask

	// 6 per program byte, 20 per row for reset and margin
	function automatic int timeout_cycles();
		int total_bytes = 0;
		for (int r = 0; r < n_rows; r++)
			total_bytes += row_len[r];
		return 6 * total_bytes + 20 * n_rows;
	endfunction

	////////////////////////////////////////////////////////////////////
	// Row execution
	////////////////////////////////////////////////////////////////////
	task automatic load_memory(input int r);
		// HLT everywhere with low bits following the address
		for (int a = 0; a < 256; a++)
			mem[a] = {HLT, a[2:0] ^ a[5:3] ^ {1'b0, a[7:6]}};
		for (int i = 0; i < row_len[r]; i++)
			mem[i] = row_prog[r][i];
		// Handler masks itself before returning
		mem[IRQ_VECTOR]        = encode(LDI, 3'd0);
		mem[IRQ_VECTOR + 8'd1] = 8'hAA;
		mem[IRQ_VECTOR + 8'd2] = encode(OUT, 3'd0);
		mem[IRQ_VECTOR + 8'd3] = encode(LMSK, 3'd0);	// acc bit 0 is clear here
		mem[IRQ_VECTOR + 8'd4] = encode(RTI, 3'd0);
	endtask

	task automatic wait_for_halt();
		do begin
			@(posedge clk);
			#1;
		end while (!halted);
	endtask

	task automatic run_row(input int r);
		load_memory(r);			// Previous row sits in HALT
		@(posedge clk);
		#1;
		arst_n   = 1'b0;
		irq      = row_irq[r];
		cur_name = row_name[r];
		cur_nexp = row_nexp[r][2:0];
		cur_exp  = '0;
		for (int i = 0; i < row_nexp[r]; i++)
			cur_exp[i*8 +: 8] = row_exp[r][i];
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;
		wait_for_halt();
		repeat (2) @(posedge clk);	// Let the checker see halted
	endtask

	// Whole-run cycle limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("Timeout: program did not halt within %0d cycles", cycle_limit);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		int total;
		arst_n   = 1'b0;
		irq      = 1'b0;
		cur_name = '0;
		cur_exp  = '0;
		cur_nexp = '0;
		n_rows   = 0;
		build_table();
		cycle_limit = timeout_cycles();
		for (int r = 0; r < n_rows; r++)
			run_row(r);
		total = chk_errors + i_dut.i_flow_ctrl.i_flow_asserts.fail_count;
		$display("Checks: %0d, errors: %0d", chk_checks, total);
		if (total == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== acc_cpu.f ====
acc_isa_pkg.sv
acc_uarch_pkg.sv
flow_ctrl.sv
alu_exec.sv
acc_result.sv
acc_cpu.sv
acc_cpu_asserts.sv
acc_cpu_checker.sv
acc_cpu_tb.sv
